// File: buffer_pkg.sv
package buffer_pkg;

    // Number of channels, one FIFO for each
    localparam int NUM_CHANNELS = 4;

    // Samples held per FIFO, which has to be a power of two
    localparam int FIFO_DEPTH = 8;

    // Address bits into the FIFO storage
    localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

    // The extra top bit tells a full FIFO from an empty one
    localparam int PTR_WIDTH = ADDR_WIDTH + 1;

    // One bit per channel, used for strobes and status vectors
    typedef logic [NUM_CHANNELS-1:0] chan_mask_t;

endpackage

// File: channel_buffer_top.sv
`timescale 1ns/1ps

module channel_buffer_top
    import stream_pkg::*, buffer_pkg::*;
(
    input  logic           clk_i,
    input  logic           reset_ni,

    input  logic           in_valid,
    input  tagged_sample_t in_sample,

    input  logic           out_ready,
    output logic           out_valid,
    output tagged_sample_t out_sample,

    output chan_mask_t     overflow
);

    chan_mask_t                 wr_en;
    sample_t                    wr_data;
    chan_mask_t                 fifo_full;
    chan_mask_t                 fifo_not_empty;
    chan_mask_t                 pop;
    chan_mask_t                 fifo_valid;
    sample_t [NUM_CHANNELS-1:0] fifo_data;

    channel_router u_router (
        .clk_i     (clk_i),
        .reset_ni  (reset_ni),
        .in_valid  (in_valid),
        .in_sample (in_sample),
        .fifo_full (fifo_full),
        .wr_en     (wr_en),
        .wr_data   (wr_data),
        .overflow  (overflow)
    );

    // One store per channel, all sharing the router's data word
    for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_fifo
        sample_fifo u_fifo (
            .clk_i     (clk_i),
            .reset_ni  (reset_ni),
            .wr_en     (wr_en[ch]),
            .wr_data   (wr_data),
            .pop       (pop[ch]),
            .rd_valid  (fifo_valid[ch]),
            .rd_data   (fifo_data[ch]),
            .not_empty (fifo_not_empty[ch]),
            .full      (fifo_full[ch])
        );
    end

    round_robin_merger u_merger (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .fifo_not_empty (fifo_not_empty),
        .out_ready      (out_ready),
        .pop            (pop),
        .fifo_valid     (fifo_valid),
        .fifo_data      (fifo_data),
        .out_valid      (out_valid),
        .out_sample     (out_sample)
    );

endmodule

// File: channel_router.sv
`timescale 1ns/1ps

module channel_router
    import stream_pkg::*, buffer_pkg::*;
(
    input  logic           clk_i,
    input  logic           reset_ni,

    input  logic           in_valid,
    input  tagged_sample_t in_sample,

    input  chan_mask_t     fifo_full,
    output chan_mask_t     wr_en,
    output sample_t        wr_data,

    output chan_mask_t     overflow
);

    chan_mask_t hit;
    chan_mask_t dropped;

    // One-hot decode of the channel tag, only for a valid input
    always_comb begin
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            hit[ch] = in_valid && (in_sample.chan == chan_t'(ch));
        end
    end

    // There is no back-pressure toward the source.
    // A sample that meets a full FIFO is simply not written
    assign wr_en   = hit & ~fifo_full;
    assign dropped = hit & fifo_full;

    // All FIFOs see the same data word, the strobe picks the target
    assign wr_data = in_sample.data;

    // Loss flags accumulate until the next reset
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            overflow <= '0;
        end else begin
            overflow <= overflow | dropped;
        end
    end

endmodule

// File: list.f
stream_pkg.sv
buffer_pkg.sv
sample_fifo.sv
channel_router.sv
round_robin_merger.sv
channel_buffer_top.sv
tb_channel_buffer_asserts.sv
tb_channel_buffer.sv

// File: round_robin_merger.sv
`timescale 1ns/1ps

module round_robin_merger
    import stream_pkg::*, buffer_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       reset_ni,

    input  chan_mask_t                 fifo_not_empty,
    input  logic                       out_ready,
    output chan_mask_t                 pop,

    input  chan_mask_t                 fifo_valid,
    input  sample_t [NUM_CHANNELS-1:0] fifo_data,

    output logic                       out_valid,
    output tagged_sample_t             out_sample
);

    // Channel that gets first look in the next arbitration
    chan_t rr_ptr;

    // Result of the search through the not-empty levels
    chan_t pick_chan;
    logic  pick_found;
    logic  grant;

    // Channel popped in the previous cycle, used to tag its sample
    chan_t last_chan;

    // Search starts at the rotation pointer and wraps around once
    always_comb begin
        int unsigned idx;
        pick_found = 1'b0;
        pick_chan  = rr_ptr;
        for (int k = 0; k < NUM_CHANNELS; k++) begin
            idx = (int'(rr_ptr) + k) % NUM_CHANNELS;
            if (!pick_found && fifo_not_empty[idx]) begin
                pick_found = 1'b1;
                pick_chan  = chan_t'(idx);
            end
        end
    end

    // Nothing is popped while the consumer cannot take a sample next cycle
    assign grant = out_ready && pick_found;

    always_comb begin
        pop = '0;
        if (grant) begin
            pop[pick_chan] = 1'b1;
        end
    end

    // The pointer moves past the served channel, so a busy channel
    // cannot starve the others
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            rr_ptr    <= '0;
            last_chan <= '0;
        end else if (grant) begin
            rr_ptr    <= chan_t'((int'(pick_chan) + 1) % NUM_CHANNELS);
            last_chan <= pick_chan;
        end
    end

    // The FIFO outputs are already registered at the pop edge.
    // Selecting them by the stored channel gives the delivery one
    // cycle after the pop, overlapped with the next pop decision
    assign out_valid       = fifo_valid[last_chan];
    assign out_sample.chan = last_chan;
    assign out_sample.data = fifo_data[last_chan];

endmodule

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
    --top-module tb_channel_buffer -f list.f -o sim_channel_buffer &&
./obj_dir/sim_channel_buffer ||
{ echo "simulation run returned an error status"; exit 1; }

// File: sample_fifo.sv
`timescale 1ns/1ps

module sample_fifo
    import stream_pkg::*, buffer_pkg::*;
(
    input  logic    clk_i,
    input  logic    reset_ni,

    input  logic    wr_en,
    input  sample_t wr_data,

    input  logic    pop,
    output logic    rd_valid,
    output sample_t rd_data,

    output logic    not_empty,
    output logic    full
);

    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic                 addr_match;
    logic                 do_write;
    logic                 do_pop;

    sample_t mem [FIFO_DEPTH];

    // Same slot but different lap means the store is full
    assign addr_match = wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0];
    assign full       = addr_match && (wr_ptr[PTR_WIDTH-1] != rd_ptr[PTR_WIDTH-1]);
    assign not_empty  = wr_ptr != rd_ptr;

    // A write into a full store is ignored, the router counts it as lost
    assign do_write = wr_en && !full;
    assign do_pop   = pop && not_empty;

    always_ff @(posedge clk_i) begin
        if (do_write) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_ptr <= '0;
        end else if (do_write) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // Read side: the head is copied out at the pop edge and valid
    // is high for exactly the following cycle
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            rd_ptr   <= '0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= do_pop;
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_pop) begin
            rd_data <= mem[rd_ptr[ADDR_WIDTH-1:0]];
        end
    end

endmodule

// File: stream_pkg.sv
package stream_pkg;

    // Width of one sample word on the stream
    localparam int SAMPLE_WIDTH = 16;

    // Width of the channel tag carried with every sample
    localparam int CHAN_WIDTH = 2;

    typedef logic [SAMPLE_WIDTH-1:0] sample_t;

    typedef logic [CHAN_WIDTH-1:0] chan_t;

    // A sample together with the channel it belongs to.
    // The tag sits in the upper bits of the packed word.
    typedef struct packed {
        chan_t   chan;
        sample_t data;
    } tagged_sample_t;

endpackage

// File: tb_channel_buffer.sv
`timescale 1ns/1ps

module tb_channel_buffer
    import stream_pkg::*, buffer_pkg::*;
();

    localparam int RESET_CYCLES  = 16;
    localparam int DRAIN_TIMEOUT = 200;
    localparam int NUM_PHASES    = 5;

    typedef enum logic [1:0] {CH_FIXED, CH_RANDOM, CH_SWEEP} chan_mode_e;
    typedef enum logic [1:0] {RDY_HIGH, RDY_LOW, RDY_RANDOM} ready_mode_e;

    // One row of the stimulus table
    typedef struct packed {
        logic [7:0]  count;
        chan_mode_e  chan_mode;
        chan_t       chan;
        ready_mode_e ready_mode;
        chan_mask_t  exp_overflow;
    } phase_t;

    logic           clk_i;
    logic           reset_ni;
    logic           in_valid;
    tagged_sample_t in_sample;
    logic           out_ready;
    logic           out_valid;
    tagged_sample_t out_sample;
    chan_mask_t     overflow;

    phase_t phases [NUM_PHASES];
    string  names [NUM_PHASES];

    // Reference model: what each FIFO should hold, its loss flags and
    // the channel the arbiter looks at first
    sample_t    model_q [NUM_CHANNELS][$];
    chan_mask_t model_ovf;
    chan_t      model_rr;

    // Pop made in the cycle that just ended, delivered in the next one
    logic  pend_valid;
    chan_t pend_chan;

    logic [31:0] rng;
    string       cur_test;

    channel_buffer_top DUT (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .in_valid   (in_valid),
        .in_sample  (in_sample),
        .out_ready  (out_ready),
        .out_valid  (out_valid),
        .out_sample (out_sample),
        .overflow   (overflow)
    );

    always #2 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic abort(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_sample(input string name, input tagged_sample_t exp,
                                input tagged_sample_t act);
        if (act !== exp) begin
            $display("Error: %s expected chan %0d data %h, actual chan %0d data %h",
                     name, exp.chan, exp.data, act.chan, act.data);
            abort("Output sample differs from the reference model");
        end
    endtask

    task automatic check_mask(input string name, input chan_mask_t exp,
                              input chan_mask_t act);
        if (act !== exp) begin
            $display("Error: %s expected overflow %b, actual overflow %b",
                     name, exp, act);
            abort("Overflow flags differ from the reference model");
        end
    endtask

    task automatic check_valid(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error: %s expected out_valid %b, actual out_valid %b",
                     name, exp, act);
            abort("Output valid pulse differs from the reference model");
        end
    endtask

    function automatic logic queues_empty();
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            if (model_q[ch].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // First channel holding data, searched from the rotation pointer
    function automatic chan_t predict_chan();
        chan_t c;
        c = model_rr;
        for (int k = 0; k < NUM_CHANNELS; k++) begin
            if (model_q[c].size() != 0) begin
                return c;
            end
            c = c + 2'd1;
        end
        return model_rr;
    endfunction

    // Advances one clock and updates the model from what the DUT saw.
    // The delivery of the pop predicted one step earlier is handled first.
    // Then comes the pop of the cycle that just ended, which still holds
    // its slot, and last the input of that cycle
    task automatic step();
        chan_t          c;
        tagged_sample_t exp;
        @(posedge clk_i);
        check_mask(cur_test, model_ovf, overflow);
        check_valid(cur_test, pend_valid, out_valid);
        if (pend_valid) begin
            exp.chan = pend_chan;
            exp.data = model_q[pend_chan][0];
            check_sample(cur_test, exp, out_sample);
            void'(model_q[pend_chan].pop_front());
        end
        pend_valid = out_ready && !queues_empty();
        if (pend_valid) begin
            pend_chan = predict_chan();
            model_rr  = pend_chan + 2'd1;
        end
        if (in_valid) begin
            c = in_sample.chan;
            if (model_q[c].size() == FIFO_DEPTH) begin
                model_ovf[c] = 1'b1;
            end else begin
                model_q[c].push_back(in_sample.data);
            end
        end
    endtask

    task automatic drain();
        int cycles;
        cycles = 0;
        in_valid  <= 1'b0;
        out_ready <= 1'b1;
        while (!queues_empty()) begin
            step();
            cycles++;
            if (cycles > DRAIN_TIMEOUT) begin
                abort($sformatf("Test %s: FIFOs did not drain within %0d cycles",
                                cur_test, DRAIN_TIMEOUT));
            end
        end
    endtask

    task automatic run_phase(input int p);
        int    sent;
        int    slot;
        logic  send;
        chan_t ch;
        sent = 0;
        slot = 0;
        cur_test = names[p];
        while (sent < int'(phases[p].count)) begin
            // Random traffic uses every other cycle so the FIFOs keep up
            send = (phases[p].chan_mode != CH_RANDOM) || (slot[0] == 1'b0);
            case (phases[p].chan_mode)
                CH_FIXED:  ch = phases[p].chan;
                CH_SWEEP:  ch = chan_t'(sent % NUM_CHANNELS);
                default: begin
                    rng = xorshift(rng);
                    ch  = rng[17:16];
                end
            endcase
            rng = xorshift(rng);
            in_valid  <= send;
            in_sample <= '{chan: ch, data: rng[15:0]};
            case (phases[p].ready_mode)
                RDY_HIGH: out_ready <= 1'b1;
                RDY_LOW:  out_ready <= 1'b0;
                default:  out_ready <= (rng[21:20] != 2'b00);
            endcase
            step();
            if (send) begin
                sent++;
            end
            slot++;
        end
        drain();
        step();
        step();
        check_mask(cur_test, phases[p].exp_overflow, overflow);
    endtask

    task automatic apply_reset();
        reset_ni  <= 1'b0;
        in_valid  <= 1'b0;
        out_ready <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            model_q[ch].delete();
        end
        model_ovf  = '0;
        model_rr   = '0;
        pend_valid = 1'b0;
        reset_ni <= 1'b1;
    endtask

    task automatic load_table();
        names[0]  = "single_channel";
        phases[0] = '{count: 8'd12, chan_mode: CH_FIXED, chan: 2'd1,
                      ready_mode: RDY_HIGH, exp_overflow: 4'b0000};
        names[1]  = "mixed_random";
        phases[1] = '{count: 8'd40, chan_mode: CH_RANDOM, chan: 2'd0,
                      ready_mode: RDY_RANDOM, exp_overflow: 4'b0000};
        names[2]  = "round_robin";
        phases[2] = '{count: 8'd12, chan_mode: CH_SWEEP, chan: 2'd0,
                      ready_mode: RDY_LOW, exp_overflow: 4'b0000};
        names[3]  = "overflow_drop";
        phases[3] = '{count: 8'd10, chan_mode: CH_FIXED, chan: 2'd2,
                      ready_mode: RDY_LOW, exp_overflow: 4'b0100};
        names[4]  = "sticky_overflow";
        phases[4] = '{count: 8'd6, chan_mode: CH_FIXED, chan: 2'd2,
                      ready_mode: RDY_HIGH, exp_overflow: 4'b0100};
    endtask

    initial begin
        clk_i      = 1'b0;
        reset_ni   = 1'b0;
        in_valid   = 1'b0;
        in_sample  = '0;
        out_ready  = 1'b0;
        rng        = 32'hb496;
        pend_valid = 1'b0;
        pend_chan  = '0;
        cur_test   = "reset";
        load_table();
        apply_reset();
        for (int p = 0; p < NUM_PHASES; p++) begin
            run_phase(p);
        end
        // Only a reset may clear the loss flags
        cur_test = "final_reset";
        apply_reset();
        step();
        check_mask(cur_test, chan_mask_t'(0), overflow);
        $display("Testbench passed");
        $finish;
    end

endmodule

// File: tb_channel_buffer_asserts.sv
`timescale 1ns/1ps

module tb_channel_buffer_asserts
    import buffer_pkg::*;
(
    input logic       clk_i,
    input logic       reset_ni,
    input logic       out_ready,
    input logic       out_valid,
    input chan_mask_t pop,
    input chan_mask_t overflow
);

    // A delivery needs a consumer that was ready one cycle earlier
    assert property (@(posedge clk_i) disable iff (!reset_ni)
        out_valid |-> $past(out_ready))
        else $error("out_valid without out_ready in the cycle before");

    // Every pop gives exactly one delivery in the following cycle
    assert property (@(posedge clk_i) disable iff (!reset_ni)
        $past(reset_ni) |-> (out_valid == $past(|pop)))
        else $error("out_valid does not follow the pop of the previous cycle");

    // Loss flags may only rise outside reset
    assert property (@(posedge clk_i) disable iff (!reset_ni)
        $past(reset_ni) |-> ((overflow & $past(overflow)) == $past(overflow)))
        else $error("an overflow flag fell outside reset");

endmodule

bind channel_buffer_top tb_channel_buffer_asserts u_asserts (
    .clk_i     (clk_i),
    .reset_ni  (reset_ni),
    .out_ready (out_ready),
    .out_valid (out_valid),
    .pop       (pop),
    .overflow  (overflow)
);
